// File: common/rab_cfg_pkg.sv
/* RAB config shared definitions */
`default_nettype none

package rab_cfg_pkg;

  // AXI4-Lite port
  localparam int AXI_ADDR_WIDTH = 32;
  localparam int AXI_DATA_WIDTH = 64;

  typedef logic [AXI_ADDR_WIDTH-1:0]   axi_addr_t;
  typedef logic [AXI_DATA_WIDTH-1:0]   axi_data_t;
  typedef logic [AXI_DATA_WIDTH/8-1:0] axi_strb_t;
  typedef logic [1:0]                  axi_resp_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // Translation widths
  localparam int ADDR_WIDTH_VIRT = 32;
  localparam int ADDR_WIDTH_PHYS = 40;
  localparam int MISS_ID_WIDTH   = 10;
  localparam int N_FLAGS         = 4;  // Valid bits in a FLAGS register

  typedef logic [ADDR_WIDTH_VIRT-1:0] virt_addr_t;
  typedef logic [MISS_ID_WIDTH-1:0]   miss_id_t;

  // Field of a slice register, low two bits of the register index
  typedef enum logic [1:0] {
    FIELD_VIRT_START = 2'd0,
    FIELD_VIRT_END   = 2'd1,
    FIELD_PHYS       = 2'd2,
    FIELD_FLAGS      = 2'd3
  } cfg_field_e;

  // Address map
  localparam int REG_ADDR_LSB    = 3;   // 8-byte registers
  localparam int MISS_WINDOW_BIT = 12;
  localparam int MISS_SEL_BIT    = 3;   // 0 = address queue, 1 = ID queue
  localparam int EMPTY_BIT       = 63;

endpackage

`default_nettype wire

// File: miss_handling/rab_mh_fifo.sv
/* Miss handling FIFO */
`timescale 1ns/1ps
`default_nettype none

module rab_mh_fifo #(
  parameter type payload_t     = logic,
  parameter int  MH_FIFO_DEPTH = 8
) (
  input  wire logic     Clk_CI,
  input  wire logic     Rst_RBI,
  input  wire logic     Push,
  input  wire payload_t PushData,
  input  wire logic     Pop,
  output payload_t      PopData,
  output logic          Full,
  output logic          Empty
);

  localparam int PTR_W = (MH_FIFO_DEPTH > 1) ? $clog2(MH_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(MH_FIFO_DEPTH + 1);

  payload_t         mem [MH_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap at the last slot, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(MH_FIFO_DEPTH-1)) ? '0 : ptr + 1'b1;
  endfunction

  assign Full    = (count == CNT_W'(MH_FIFO_DEPTH));
  assign Empty   = (count == '0);
  assign do_push = Push & ~Full;
  assign do_pop  = Pop & ~Empty;
  assign PopData = mem[rd_ptr];  // Oldest entry

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_next(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_next(rd_ptr);
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (do_push)
      mem[wr_ptr] <= PushData;
  end

endmodule

`default_nettype wire

// File: miss_handling/rab_mh_queue.sv
/* Miss address and ID queues */
`timescale 1ns/1ps
`default_nettype none

module rab_mh_queue #(
  parameter int MH_FIFO_DEPTH = 8
) (
  input  wire logic                    Clk_CI,
  input  wire logic                    Rst_RBI,
  input  wire rab_cfg_pkg::virt_addr_t MissAddr_DI,
  input  wire rab_cfg_pkg::miss_id_t   MissId_DI,
  input  wire logic                    Miss_SI,
  input  wire logic                    MissRdEn,
  input  wire rab_cfg_pkg::axi_addr_t  RdAddr,
  output rab_cfg_pkg::axi_data_t       MissRdData,
  output logic                         MhFifoFull_SO
);

  logic                    sel_id;
  logic                    addr_pop;
  logic                    addr_full;
  logic                    addr_empty;
  logic                    id_pop;
  logic                    id_full;
  logic                    id_empty;
  rab_cfg_pkg::virt_addr_t addr_head;
  rab_cfg_pkg::miss_id_t   id_head;

  assign sel_id   = RdAddr[rab_cfg_pkg::MISS_SEL_BIT];
  assign addr_pop = MissRdEn & ~sel_id & ~addr_empty;
  assign id_pop   = MissRdEn & sel_id & ~id_empty;

  // Overflow on a miss that finds a queue full
  assign MhFifoFull_SO = Miss_SI & (addr_full | id_full);

  rab_mh_fifo #(
    .payload_t     (rab_cfg_pkg::virt_addr_t),
    .MH_FIFO_DEPTH (MH_FIFO_DEPTH)
  ) addr_fifo_i (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .Push     (Miss_SI),
    .PushData (MissAddr_DI),
    .Pop      (addr_pop),
    .PopData  (addr_head),
    .Full     (addr_full),
    .Empty    (addr_empty)
  );

  rab_mh_fifo #(
    .payload_t     (rab_cfg_pkg::miss_id_t),
    .MH_FIFO_DEPTH (MH_FIFO_DEPTH)
  ) id_fifo_i (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .Push     (Miss_SI),
    .PushData (MissId_DI),
    .Pop      (id_pop),
    .PopData  (id_head),
    .Full     (id_full),
    .Empty    (id_empty)
  );

  // Read word: empty flag on top, head entry in the low bits
  always_comb
  begin
    MissRdData = '0;
    if (sel_id)
    begin
      MissRdData[rab_cfg_pkg::EMPTY_BIT] = id_empty;
      if (!id_empty)
        MissRdData[rab_cfg_pkg::MISS_ID_WIDTH-1:0] = id_head;
    end
    else
    begin
      MissRdData[rab_cfg_pkg::EMPTY_BIT] = addr_empty;
      if (!addr_empty)
        MissRdData[rab_cfg_pkg::ADDR_WIDTH_VIRT-1:0] = addr_head;
    end
  end

endmodule

`default_nettype wire

// File: source/rab_cfg_l1_regs.sv
/* L1 slice register bank */
`timescale 1ns/1ps
`default_nettype none

module rab_cfg_l1_regs #(
  parameter int N_SLICES = 4
) (
  input  wire logic                   Clk_CI,
  input  wire logic                   Rst_RBI,
  input  wire logic                   CfgWrEn,
  input  wire rab_cfg_pkg::axi_addr_t WrAddr,
  input  wire rab_cfg_pkg::axi_data_t WrData,
  input  wire rab_cfg_pkg::axi_strb_t WrStrb,
  input  wire rab_cfg_pkg::axi_addr_t RdAddr,
  output rab_cfg_pkg::axi_data_t      CfgRdData,
  output rab_cfg_pkg::axi_data_t      L1Cfg_DO [4*N_SLICES]
);

  localparam int N_REGS = 4*N_SLICES;
  localparam int IDX_W  = $clog2(N_REGS);
  localparam int IDX_FULL_W = rab_cfg_pkg::AXI_ADDR_WIDTH - rab_cfg_pkg::REG_ADDR_LSB;

  logic [IDX_FULL_W-1:0]   wr_idx;
  logic [IDX_FULL_W-1:0]   rd_idx;
  logic                    wr_hit;
  rab_cfg_pkg::cfg_field_e wr_field;
  rab_cfg_pkg::axi_data_t  field_mask;
  rab_cfg_pkg::axi_data_t  strb_mask;
  rab_cfg_pkg::axi_data_t  wr_mask;

  assign wr_idx   = WrAddr[rab_cfg_pkg::AXI_ADDR_WIDTH-1:rab_cfg_pkg::REG_ADDR_LSB];
  assign rd_idx   = RdAddr[rab_cfg_pkg::AXI_ADDR_WIDTH-1:rab_cfg_pkg::REG_ADDR_LSB];
  assign wr_field = rab_cfg_pkg::cfg_field_e'(wr_idx[1:0]);
  assign wr_hit   = CfgWrEn && (wr_idx < N_REGS);  // Out-of-range writes dropped

  // Bits a field can hold
  always_comb
  begin
    field_mask = '0;
    case (wr_field)
      rab_cfg_pkg::FIELD_VIRT_START,
      rab_cfg_pkg::FIELD_VIRT_END: field_mask[rab_cfg_pkg::ADDR_WIDTH_VIRT-1:0] = '1;
      rab_cfg_pkg::FIELD_PHYS:     field_mask[rab_cfg_pkg::ADDR_WIDTH_PHYS-1:0] = '1;
      rab_cfg_pkg::FIELD_FLAGS:    field_mask[rab_cfg_pkg::N_FLAGS-1:0] = '1;
    endcase
  end

  always_comb
  begin
    for (int b = 0; b < rab_cfg_pkg::AXI_DATA_WIDTH/8; b++)
      strb_mask[8*b +: 8] = {8{WrStrb[b]}};
  end

  assign wr_mask = field_mask & strb_mask;

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      for (int i = 0; i < N_REGS; i++)
        L1Cfg_DO[i] <= '0;
    end
    else if (wr_hit)
      L1Cfg_DO[wr_idx[IDX_W-1:0]] <= (L1Cfg_DO[wr_idx[IDX_W-1:0]] & ~wr_mask)
                                     | (WrData & wr_mask);  // Strobe merge
  end

  assign CfgRdData = (rd_idx < N_REGS) ? L1Cfg_DO[rd_idx[IDX_W-1:0]] : '0;

endmodule

`default_nettype wire

// File: source/rab_cfg_axi_lite_slave.sv
/* AXI4-Lite slave for RAB config */
`timescale 1ns/1ps
`default_nettype none

module rab_cfg_axi_lite_slave (
  input  wire logic                   Clk_CI,
  input  wire logic                   Rst_RBI,
  input  wire rab_cfg_pkg::axi_addr_t awaddr,
  input  wire logic                   awvalid,
  output logic                        awready,
  input  wire rab_cfg_pkg::axi_data_t wdata,
  input  wire rab_cfg_pkg::axi_strb_t wstrb,
  input  wire logic                   wvalid,
  output logic                        wready,
  output rab_cfg_pkg::axi_resp_t      bresp,
  output logic                        bvalid,
  input  wire logic                   bready,
  input  wire rab_cfg_pkg::axi_addr_t araddr,
  input  wire logic                   arvalid,
  output logic                        arready,
  output rab_cfg_pkg::axi_data_t      rdata,
  output rab_cfg_pkg::axi_resp_t      rresp,
  output logic                        rvalid,
  input  wire logic                   rready,
  input  wire rab_cfg_pkg::axi_data_t CfgRdData,
  input  wire rab_cfg_pkg::axi_data_t MissRdData,
  output logic                        CfgWrEn,
  output rab_cfg_pkg::axi_addr_t      WrAddr,
  output rab_cfg_pkg::axi_data_t      WrData,
  output rab_cfg_pkg::axi_strb_t      WrStrb,
  output rab_cfg_pkg::axi_addr_t      RdAddr,
  output logic                        MissRdEn
);

  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;
  logic both_held;
  logic both_held_q;  // Delayed copy for edge detect

  assign aw_hs = awready & awvalid;
  assign w_hs  = wready & wvalid;
  assign ar_hs = arready & arvalid;
  assign r_hs  = rvalid & rready;

  // Address and data both captured, response pending until B handshake
  assign both_held = ~awready & ~wready;
  assign bvalid    = both_held;
  assign b_hs      = bvalid & bready;
  assign bresp     = rab_cfg_pkg::RESP_OKAY;

  // One-cycle write pulse, config window only
  assign CfgWrEn = both_held & ~both_held_q & ~WrAddr[rab_cfg_pkg::MISS_WINDOW_BIT];

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      awready     <= 1'b1;
      wready      <= 1'b1;
      both_held_q <= 1'b0;
    end
    else
    begin
      both_held_q <= both_held;
      if (aw_hs)
        awready <= 1'b0;
      else if (b_hs)
        awready <= 1'b1;
      if (w_hs)
        wready <= 1'b0;
      else if (b_hs)
        wready <= 1'b1;
    end
  end

  // Write payload
  always_ff @(posedge Clk_CI)
  begin
    if (aw_hs)
      WrAddr <= awaddr;
    if (w_hs)
    begin
      WrData <= wdata;
      WrStrb <= wstrb;
    end
  end

  // Read sources decode straight from the AR address
  assign RdAddr   = araddr;
  assign MissRdEn = ar_hs & araddr[rab_cfg_pkg::MISS_WINDOW_BIT];
  assign rvalid   = ~arready;  // Busy from AR accept until R handshake
  assign rresp    = rab_cfg_pkg::RESP_OKAY;

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      arready <= 1'b1;
    else if (ar_hs)
      arready <= 1'b0;
    else if (r_hs)
      arready <= 1'b1;
  end

  always_ff @(posedge Clk_CI)
  begin
    if (ar_hs)
      rdata <= araddr[rab_cfg_pkg::MISS_WINDOW_BIT] ? MissRdData : CfgRdData;
  end

endmodule

`default_nettype wire

// File: source/axi_rab_cfg.sv
/* RAB config and miss handling */
`timescale 1ns/1ps
`default_nettype none

module axi_rab_cfg #(
  parameter int N_SLICES      = 4,
  parameter int MH_FIFO_DEPTH = 8
) (
  input  wire logic                   Clk_CI,
  input  wire logic                   Rst_RBI,
  // AXI4-Lite slave
  input  wire rab_cfg_pkg::axi_addr_t awaddr,
  input  wire logic                   awvalid,
  output logic                        awready,
  input  wire rab_cfg_pkg::axi_data_t wdata,
  input  wire rab_cfg_pkg::axi_strb_t wstrb,
  input  wire logic                   wvalid,
  output logic                        wready,
  output rab_cfg_pkg::axi_resp_t      bresp,
  output logic                        bvalid,
  input  wire logic                   bready,
  input  wire rab_cfg_pkg::axi_addr_t araddr,
  input  wire logic                   arvalid,
  output logic                        arready,
  output rab_cfg_pkg::axi_data_t      rdata,
  output rab_cfg_pkg::axi_resp_t      rresp,
  output logic                        rvalid,
  input  wire logic                   rready,
  // Miss input
  input  wire rab_cfg_pkg::virt_addr_t MissAddr_DI,
  input  wire rab_cfg_pkg::miss_id_t   MissId_DI,
  input  wire logic                    Miss_SI,
  output logic                         MhFifoFull_SO,
  // Slice configuration
  output rab_cfg_pkg::axi_data_t       L1Cfg_DO [4*N_SLICES]
);

  logic                   cfg_wr_en;
  logic                   miss_rd_en;
  rab_cfg_pkg::axi_addr_t wr_addr;
  rab_cfg_pkg::axi_addr_t rd_addr;
  rab_cfg_pkg::axi_data_t wr_data;
  rab_cfg_pkg::axi_strb_t wr_strb;
  rab_cfg_pkg::axi_data_t cfg_rd_data;
  rab_cfg_pkg::axi_data_t miss_rd_data;

  rab_cfg_axi_lite_slave slave_i (
    .Clk_CI     (Clk_CI),
    .Rst_RBI    (Rst_RBI),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .CfgRdData  (cfg_rd_data),
    .MissRdData (miss_rd_data),
    .CfgWrEn    (cfg_wr_en),
    .WrAddr     (wr_addr),
    .WrData     (wr_data),
    .WrStrb     (wr_strb),
    .RdAddr     (rd_addr),
    .MissRdEn   (miss_rd_en)
  );

  rab_cfg_l1_regs #(
    .N_SLICES (N_SLICES)
  ) l1_regs_i (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .CfgWrEn   (cfg_wr_en),
    .WrAddr    (wr_addr),
    .WrData    (wr_data),
    .WrStrb    (wr_strb),
    .RdAddr    (rd_addr),
    .CfgRdData (cfg_rd_data),
    .L1Cfg_DO  (L1Cfg_DO)
  );

  rab_mh_queue #(
    .MH_FIFO_DEPTH (MH_FIFO_DEPTH)
  ) mh_queue_i (
    .Clk_CI        (Clk_CI),
    .Rst_RBI       (Rst_RBI),
    .MissAddr_DI   (MissAddr_DI),
    .MissId_DI     (MissId_DI),
    .Miss_SI       (Miss_SI),
    .MissRdEn      (miss_rd_en),
    .RdAddr        (rd_addr),
    .MissRdData    (miss_rd_data),
    .MhFifoFull_SO (MhFifoFull_SO)
  );

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
/* Testbench clock and reset */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int RST_CYCLES = 4
) (
  output logic Clk_CI,
  output logic Rst_RBI
);

  initial
  begin
    Clk_CI = 1'b0;
    forever #2 Clk_CI = ~Clk_CI;  // 4 ns period
  end

  initial
  begin
    Rst_RBI = 1'b0;
    repeat (RST_CYCLES) @(posedge Clk_CI);
    Rst_RBI <= 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/tb_axi_rab_cfg.sv
/* RAB config testbench */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_rab_cfg;

  localparam int N_SLICES      = 4;
  localparam int MH_FIFO_DEPTH = 8;
  localparam int N_REGS        = 4*N_SLICES;
  localparam int MAX_WAIT      = 100;  // Cycles allowed per handshake

  localparam rab_cfg_pkg::axi_addr_t MISS_ADDR_Q = 32'd1 << rab_cfg_pkg::MISS_WINDOW_BIT;
  localparam rab_cfg_pkg::axi_addr_t MISS_ID_Q   =
    MISS_ADDR_Q | (32'd1 << rab_cfg_pkg::MISS_SEL_BIT);

  logic                    Clk_CI;
  logic                    Rst_RBI;
  rab_cfg_pkg::axi_addr_t  awaddr;
  logic                    awvalid;
  logic                    awready;
  rab_cfg_pkg::axi_data_t  wdata;
  rab_cfg_pkg::axi_strb_t  wstrb;
  logic                    wvalid;
  logic                    wready;
  rab_cfg_pkg::axi_resp_t  bresp;
  logic                    bvalid;
  logic                    bready;
  rab_cfg_pkg::axi_addr_t  araddr;
  logic                    arvalid;
  logic                    arready;
  rab_cfg_pkg::axi_data_t  rdata;
  rab_cfg_pkg::axi_resp_t  rresp;
  logic                    rvalid;
  logic                    rready;
  rab_cfg_pkg::virt_addr_t miss_addr;
  rab_cfg_pkg::miss_id_t   miss_id;
  logic                    miss;
  logic                    mh_full;
  rab_cfg_pkg::axi_data_t  l1_cfg [N_REGS];

  rab_cfg_pkg::axi_data_t  exp_regs [N_REGS];  // Reference copy of the register bank
  int                      seed = 32'h2317_a6f9;
  int                      errors;
  int                      checks;
  int                      tests_run;
  int                      errs_before;
  int                      wait_cnt;
  bit                      timed_out;

  tb_clk_gen #(.RST_CYCLES(4)) clk_gen_i (.Clk_CI(Clk_CI), .Rst_RBI(Rst_RBI));

  axi_rab_cfg #(
    .N_SLICES      (N_SLICES),
    .MH_FIFO_DEPTH (MH_FIFO_DEPTH)
  ) dut_i (
    .Clk_CI (Clk_CI), .Rst_RBI (Rst_RBI),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata  (wdata),  .wstrb   (wstrb),   .wvalid  (wvalid), .wready (wready),
    .bresp  (bresp),  .bvalid  (bvalid),  .bready  (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata  (rdata),  .rresp   (rresp),   .rvalid  (rvalid), .rready (rready),
    .MissAddr_DI (miss_addr), .MissId_DI (miss_id), .Miss_SI (miss),
    .MhFifoFull_SO (mh_full),
    .L1Cfg_DO (l1_cfg)
  );

  task automatic check_data(input string what, input rab_cfg_pkg::axi_data_t got,
                            input rab_cfg_pkg::axi_data_t exp);
    if (timed_out)
      return;
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input string what, input rab_cfg_pkg::axi_resp_t got,
                            input rab_cfg_pkg::axi_resp_t exp);
    if (timed_out)
      return;
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %t: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (timed_out)
      return;
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %t: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    timed_out = 1'b1;
    errors++;
    $display("Timeout at %t: %s within %0d cycles", $time, what, MAX_WAIT);
  endtask

  // Expected register after a write under the field byte ranges
  function automatic rab_cfg_pkg::axi_data_t merge_field(input rab_cfg_pkg::axi_data_t old,
      input rab_cfg_pkg::axi_data_t data, input rab_cfg_pkg::axi_strb_t strb, input int idx);
    rab_cfg_pkg::axi_data_t res;
    int                     n_bytes;
    res = old;
    case (idx % 4)
      0, 1:    n_bytes = 4;  // Virtual start and end
      2:       n_bytes = 5;  // Physical address
      default: n_bytes = 1;  // Flags
    endcase
    for (int b = 0; b < n_bytes; b++)
      if (strb[b])
        res[8*b +: 8] = data[8*b +: 8];
    if (idx % 4 == 3)
      res = res & ((64'd1 << rab_cfg_pkg::N_FLAGS) - 64'd1);
    return res;
  endfunction

  function automatic rab_cfg_pkg::axi_data_t miss_word(input logic empty,
                                                       input rab_cfg_pkg::axi_data_t payload);
    rab_cfg_pkg::axi_data_t w;
    w = payload;
    w[rab_cfg_pkg::EMPTY_BIT] = empty;
    return w;
  endfunction

  function automatic rab_cfg_pkg::virt_addr_t series_addr(input int i);
    return 32'h8000_0000 + 32'(i) * 32'h0001_1000;
  endfunction

  function automatic rab_cfg_pkg::miss_id_t series_id(input int i);
    return rab_cfg_pkg::miss_id_t'(3 + 37*i);
  endfunction

  task automatic send_aw(input rab_cfg_pkg::axi_addr_t addr);
    int n;
    if (timed_out)
      return;
    n = 0;
    @(posedge Clk_CI);
    awaddr  <= addr;
    awvalid <= 1'b1;
    @(negedge Clk_CI);
    while (!awready && n < MAX_WAIT)
    begin
      @(negedge Clk_CI);
      n++;
    end
    if (!awready)
      note_timeout("no awready from DUT");
    @(posedge Clk_CI);
    awvalid <= 1'b0;
  endtask

  task automatic send_w(input rab_cfg_pkg::axi_data_t data, input rab_cfg_pkg::axi_strb_t strb);
    int n;
    if (timed_out)
      return;
    n = 0;
    @(posedge Clk_CI);
    wdata  <= data;
    wstrb  <= strb;
    wvalid <= 1'b1;
    @(negedge Clk_CI);
    while (!wready && n < MAX_WAIT)
    begin
      @(negedge Clk_CI);
      n++;
    end
    if (!wready)
      note_timeout("no wready from DUT");
    @(posedge Clk_CI);
    wvalid <= 1'b0;
  endtask

  // Hold bready low for some cycles before accepting B
  task automatic take_b(input int hold);
    int n;
    if (timed_out)
      return;
    n = 0;
    @(negedge Clk_CI);
    while (!bvalid && n < MAX_WAIT)
    begin
      @(negedge Clk_CI);
      n++;
    end
    if (!bvalid)
    begin
      note_timeout("no bvalid from DUT");
      return;
    end
    check_resp("bresp", bresp, rab_cfg_pkg::RESP_OKAY);
    repeat (hold)
    begin
      @(negedge Clk_CI);
      check_bit("bvalid held under back-pressure", bvalid, 1'b1);
    end
    @(posedge Clk_CI);
    bready <= 1'b1;
    @(posedge Clk_CI);
    bready <= 1'b0;
    @(negedge Clk_CI);
    check_bit("bvalid after B handshake", bvalid, 1'b0);  // One B per write
  endtask

  // Order 0 sends AW and W together, 1 sends AW first, 2 sends W first
  task automatic axi_write(input rab_cfg_pkg::axi_addr_t addr, input rab_cfg_pkg::axi_data_t data,
                           input rab_cfg_pkg::axi_strb_t strb, input int order, input int hold);
    case (order)
      0:
      begin
        fork
          send_aw(addr);
          send_w(data, strb);
        join
      end
      1:
      begin
        send_aw(addr);
        send_w(data, strb);
      end
      default:
      begin
        send_w(data, strb);
        send_aw(addr);
      end
    endcase
    take_b(hold);
  endtask

  task automatic axi_read(input rab_cfg_pkg::axi_addr_t addr, input int hold,
                          output rab_cfg_pkg::axi_data_t data);
    int                     n;
    rab_cfg_pkg::axi_data_t first;
    data = '0;
    if (timed_out)
      return;
    n = 0;
    @(posedge Clk_CI);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge Clk_CI);
    while (!arready && n < MAX_WAIT)
    begin
      @(negedge Clk_CI);
      n++;
    end
    if (!arready)
    begin
      note_timeout("no arready from DUT");
      return;
    end
    @(posedge Clk_CI);
    arvalid <= 1'b0;
    n = 0;
    @(negedge Clk_CI);
    while (!rvalid && n < MAX_WAIT)
    begin
      @(negedge Clk_CI);
      n++;
    end
    if (!rvalid)
    begin
      note_timeout("no rvalid from DUT");
      return;
    end
    first = rdata;
    check_resp("rresp", rresp, rab_cfg_pkg::RESP_OKAY);
    repeat (hold)
    begin
      @(negedge Clk_CI);
      check_bit("rvalid held under back-pressure", rvalid, 1'b1);
      check_data("rdata held under back-pressure", rdata, first);
    end
    @(posedge Clk_CI);
    rready <= 1'b1;
    @(posedge Clk_CI);
    rready <= 1'b0;
    data = first;
  endtask

  task automatic push_miss(input rab_cfg_pkg::virt_addr_t addr, input rab_cfg_pkg::miss_id_t id,
                           output logic full);
    @(posedge Clk_CI);
    miss_addr <= addr;
    miss_id   <= id;
    miss      <= 1'b1;
    @(negedge Clk_CI);
    full = mh_full;  // Overflow shows in the strobe cycle
    @(posedge Clk_CI);
    miss <= 1'b0;
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start)
      $display("Test %-16s ok", name);
    else
      $display("Test %-16s %0d errors", name, errors - errs_at_start);
  endtask

  task automatic reset_values();
    rab_cfg_pkg::axi_data_t rd;
    @(negedge Clk_CI);
    check_bit("awready after reset", awready, 1'b1);
    check_bit("wready after reset", wready, 1'b1);
    check_bit("arready after reset", arready, 1'b1);
    check_bit("bvalid after reset", bvalid, 1'b0);
    check_bit("rvalid after reset", rvalid, 1'b0);
    check_bit("MhFifoFull_SO after reset", mh_full, 1'b0);
    for (int i = 0; i < N_REGS; i++)
      check_data("L1Cfg_DO after reset", l1_cfg[i], '0);
    for (int i = 0; i < N_REGS; i++)
    begin
      axi_read(32'(i) << rab_cfg_pkg::REG_ADDR_LSB, 0, rd);
      check_data("register read after reset", rd, '0);
    end
  endtask

  task automatic field_masks();
    rab_cfg_pkg::axi_data_t data;
    rab_cfg_pkg::axi_strb_t strb;
    rab_cfg_pkg::axi_data_t rd;
    // Second pass merges into the values of the first
    for (int pass = 0; pass < 2; pass++)
      for (int i = 0; i < N_REGS; i++)
      begin
        data = {$random(seed), $random(seed)};
        strb = rab_cfg_pkg::axi_strb_t'($random(seed));
        axi_write(32'(i) << rab_cfg_pkg::REG_ADDR_LSB, data, strb, 0, 0);
        exp_regs[i] = merge_field(exp_regs[i], data, strb, i);
        check_data("L1Cfg_DO after write", l1_cfg[i], exp_regs[i]);
        axi_read(32'(i) << rab_cfg_pkg::REG_ADDR_LSB, 0, rd);
        check_data("register readback", rd, exp_regs[i]);
      end
    axi_write(32'(N_REGS) << rab_cfg_pkg::REG_ADDR_LSB, '1, '1, 0, 0);  // Out of range
    axi_write(MISS_ADDR_Q, '1, '1, 0, 0);
    axi_write(MISS_ID_Q, '1, '1, 0, 0);
    for (int i = 0; i < N_REGS; i++)
      check_data("L1Cfg_DO after ignored writes", l1_cfg[i], exp_regs[i]);
    axi_read(32'(N_REGS) << rab_cfg_pkg::REG_ADDR_LSB, 0, rd);
    check_data("out-of-range read", rd, '0);
    axi_read(MISS_ADDR_Q, 0, rd);
    check_data("address queue after miss window write", rd, miss_word(1'b1, '0));
    axi_read(MISS_ID_Q, 0, rd);
    check_data("ID queue after miss window write", rd, miss_word(1'b1, '0));
  endtask

  task automatic channel_order();
    rab_cfg_pkg::axi_data_t data;
    rab_cfg_pkg::axi_strb_t strb;
    rab_cfg_pkg::axi_data_t rd;
    data = {$random(seed), $random(seed)};
    strb = rab_cfg_pkg::axi_strb_t'($random(seed));
    axi_write(32'd5 << rab_cfg_pkg::REG_ADDR_LSB, data, strb, 2, 5);  // W before AW
    exp_regs[5] = merge_field(exp_regs[5], data, strb, 5);
    check_data("L1Cfg_DO after W-first write", l1_cfg[5], exp_regs[5]);
    data = {$random(seed), $random(seed)};
    strb = rab_cfg_pkg::axi_strb_t'($random(seed));
    axi_write(32'd10 << rab_cfg_pkg::REG_ADDR_LSB, data, strb, 1, 3);  // AW before W
    exp_regs[10] = merge_field(exp_regs[10], data, strb, 10);
    check_data("L1Cfg_DO after AW-first write", l1_cfg[10], exp_regs[10]);
    axi_read(32'd5 << rab_cfg_pkg::REG_ADDR_LSB, 6, rd);
    check_data("held readback", rd, exp_regs[5]);
    axi_read(32'd10 << rab_cfg_pkg::REG_ADDR_LSB, 4, rd);
    check_data("held readback", rd, exp_regs[10]);
  endtask

  task automatic miss_order();
    rab_cfg_pkg::axi_data_t rd;
    logic                   full;
    for (int i = 0; i < 5; i++)
    begin
      push_miss(series_addr(i), series_id(i), full);
      check_bit("MhFifoFull_SO on miss", full, 1'b0);
    end
    // Config reads whose select bit points at either queue must not pop it
    axi_read(32'd0, 0, rd);
    check_data("config read with misses queued", rd, exp_regs[0]);
    axi_read(32'd1 << rab_cfg_pkg::REG_ADDR_LSB, 0, rd);
    check_data("config read with misses queued", rd, exp_regs[1]);
    for (int i = 0; i < 5; i++)
    begin
      axi_read(MISS_ADDR_Q, i % 3, rd);
      check_data("address queue entry", rd, miss_word(1'b0, 64'(series_addr(i))));
    end
    axi_read(MISS_ADDR_Q, 0, rd);
    check_data("drained address queue", rd, miss_word(1'b1, '0));
    for (int i = 0; i < 5; i++)
    begin
      axi_read(MISS_ID_Q, 0, rd);
      check_data("ID queue entry", rd, miss_word(1'b0, 64'(series_id(i))));
    end
    axi_read(MISS_ID_Q, 0, rd);
    check_data("drained ID queue", rd, miss_word(1'b1, '0));
  endtask

  task automatic overflow_drop();
    rab_cfg_pkg::virt_addr_t addrs [MH_FIFO_DEPTH+1];
    rab_cfg_pkg::miss_id_t   ids   [MH_FIFO_DEPTH+1];
    rab_cfg_pkg::axi_data_t  rd;
    logic                    full;
    for (int i = 0; i <= MH_FIFO_DEPTH; i++)
    begin
      addrs[i] = $random(seed);
      ids[i]   = rab_cfg_pkg::miss_id_t'($random(seed));
      push_miss(addrs[i], ids[i], full);
      check_bit("MhFifoFull_SO while filling", full, i == MH_FIFO_DEPTH);
    end
    @(negedge Clk_CI);
    check_bit("MhFifoFull_SO without strobe", mh_full, 1'b0);
    for (int i = 0; i < MH_FIFO_DEPTH; i++)
    begin
      axi_read(MISS_ADDR_Q, 0, rd);
      check_data("address queue after overflow", rd, miss_word(1'b0, 64'(addrs[i])));
    end
    axi_read(MISS_ADDR_Q, 0, rd);
    check_data("dropped address absent", rd, miss_word(1'b1, '0));
    for (int i = 0; i < MH_FIFO_DEPTH; i++)
    begin
      axi_read(MISS_ID_Q, 0, rd);
      check_data("ID queue after overflow", rd, miss_word(1'b0, 64'(ids[i])));
    end
    axi_read(MISS_ID_Q, 0, rd);
    check_data("dropped ID absent", rd, miss_word(1'b1, '0));
  endtask

  initial
  begin
    $timeformat(-9, 0, " ns", 0);
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    miss_addr = '0;
    miss_id   = '0;
    miss      = 1'b0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    timed_out = 1'b0;
    for (int i = 0; i < N_REGS; i++)
      exp_regs[i] = '0;

    wait_cnt = 0;
    while (Rst_RBI !== 1'b1 && wait_cnt < MAX_WAIT)
    begin
      @(posedge Clk_CI);
      wait_cnt++;
    end
    if (Rst_RBI !== 1'b1)
      note_timeout("reset was not released");

    errs_before = errors;
    reset_values();
    report_test("reset_values", errs_before);
    errs_before = errors;
    field_masks();
    report_test("field_masks", errs_before);
    errs_before = errors;
    channel_order();
    report_test("channel_order", errs_before);
    errs_before = errors;
    miss_order();
    report_test("miss_order", errs_before);
    errs_before = errors;
    overflow_drop();
    report_test("overflow_drop", errs_before);

    $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0 && !timed_out)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
common/rab_cfg_pkg.sv
miss_handling/rab_mh_fifo.sv
miss_handling/rab_mh_queue.sv
source/rab_cfg_l1_regs.sv
source/rab_cfg_axi_lite_slave.sv
source/axi_rab_cfg.sv
verification/tb_clk_gen.sv
verification/tb_axi_rab_cfg.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the RAB config testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing -Wno-fatal --top-module tb_axi_rab_cfg \
  --Mdir "$BUILD" -o tb_axi_rab_cfg -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$BUILD/tb_axi_rab_cfg" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
